/* dcache.f */
logic/dcache_pkg.sv
logic/dcache_way_if.sv
logic/dcache_way.sv
logic/dcache_lookup.sv
logic/dcache_lru.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tb/dcache_tb_mem.sv
tb/dcache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = dcache_tb
FILELIST  = dcache.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb/dcache_tb.sv */
// testbench for the two-way data cache that runs directed cases and then a random load/store mix
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD  = 100;
    localparam logic [31:0] SEED        = 32'h731a;
    localparam int          NUM_OPS     = 400;
    localparam int          CYCLE_LIMIT = NUM_OPS * 20;
    // sampled in IDLE, then LOOKUP, done in HIT
    localparam int          HIT_CYCLES  = 3;

    logic               clk;
    logic               rst;
    dcache_pkg::addr_t  mem_addr;
    dcache_pkg::data_u  mem_wdata;
    dcache_pkg::mask_t  mem_mask;
    logic               mem_read;
    logic               mem_write;
    dcache_pkg::data_u  mem_rdata;
    logic               mem_done;
    dcache_pkg::addr_t  bus_addr;
    dcache_pkg::data_u  bus_wdata;
    logic               bus_read;
    logic               bus_write;
    dcache_pkg::data_u  bus_rdata;
    logic               bus_ok;

    dcache_pkg::data_u  ref_mem [dcache_pkg::addr_t];
    dcache_pkg::data_u  expected;
    logic [31:0]        lfsr = SEED;
    int                 data_errors = 0;
    int                 addr_errors = 0;
    int                 other_errors = 0;
    int                 cycle_count;
    // bus activity seen during the last access
    int                 op_cycles;
    logic               saw_read;
    logic               saw_write;
    logic               read_first;
    dcache_pkg::addr_t  rd_addr;
    dcache_pkg::addr_t  wb_addr;

    dcache_top dcache_top_i (
        .clk         (clk),
        .rst         (rst),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_mask_i  (mem_mask),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .mem_rdata_o (mem_rdata),
        .mem_done_o  (mem_done),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_read_o  (bus_read),
        .bus_write_o (bus_write),
        .bus_rdata_i (bus_rdata),
        .bus_ok_i    (bus_ok)
    );

    dcache_tb_mem dcache_tb_mem_i (
        .clk         (clk),
        .rst         (rst),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_read_i  (bus_read),
        .bus_write_i (bus_write),
        .bus_rdata_o (bus_rdata),
        .bus_ok_o    (bus_ok)
    );

    // same address pattern as the backing memory for untouched words
    function automatic dcache_pkg::data_u fill_word(input dcache_pkg::addr_t a);
        dcache_pkg::data_u w;
        w.word = {a[31:0] ^ 32'h5a5a_c3c3, a[63:32] ^ a[31:0]};
        return w;
    endfunction

    function automatic dcache_pkg::data_u ref_word(input dcache_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // enabled bytes come from the store and the rest keep the old word
    function automatic dcache_pkg::data_u merge_store(input dcache_pkg::data_u old_w,
                                                      input dcache_pkg::data_u new_w,
                                                      input dcache_pkg::mask_t m);
        dcache_pkg::data_u res;
        res = old_w;
        for (int b = 0; b < 8; b++) begin
            if (m[b]) begin
                res.word[b*8 +: 8] = new_w.word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input dcache_pkg::tag_t tag,
                                                    input dcache_pkg::index_t idx);
        return {tag, idx, 3'b000};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic compare_data(input string name, input dcache_pkg::data_u got,
                                input dcache_pkg::data_u exp);
        if (got.word !== exp.word) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got.word, exp.word);
            data_errors++;
        end
    endtask

    task automatic compare_addr(input string name, input dcache_pkg::addr_t got,
                                input dcache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            addr_errors++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        if (!ok) begin
            $display("%s", what);
            other_errors++;
        end
    endtask

    // one core request held until done and dropped for the idle cycle
    task automatic access(input dcache_pkg::addr_t a, input logic wr,
                          input dcache_pkg::data_u d, input dcache_pkg::mask_t m);
        op_cycles = 0;
        saw_read = 1'b0;
        saw_write = 1'b0;
        read_first = 1'b0;
        if (wr) begin
            ref_mem[a] = merge_store(ref_word(a), d, m);
        end else begin
            expected = ref_word(a);
        end
        mem_addr = a;
        mem_wdata = d;
        mem_mask = m;
        mem_read = !wr;
        mem_write = wr;
        do begin
            @(negedge clk);
            op_cycles++;
            if (bus_read && !saw_read) begin
                rd_addr = bus_addr;
                read_first = !saw_write;
                saw_read = 1'b1;
            end
            if (bus_write && !saw_write) begin
                wb_addr = bus_addr;
                saw_write = 1'b1;
            end
        end while (!mem_done);
        @(posedge clk);
        #1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    // load results and writeback data against the reference memory
    always @(negedge clk) begin
        if (mem_done && mem_read) begin
            compare_data("mem_rdata_o", mem_rdata, expected);
        end
        if (bus_write && bus_ok) begin
            compare_data("bus_wdata_o", bus_wdata, ref_word(bus_addr));
        end
    end

    initial begin
        dcache_pkg::addr_t a;
        dcache_pkg::addr_t b;
        dcache_pkg::addr_t c;
        dcache_pkg::data_u d;
        logic [31:0]       tag_bits;
        logic [31:0]       idx_bits;
        logic [31:0]       wr_bits;
        logic [31:0]       mask_bits;
        logic [31:0]       hi;
        logic [31:0]       lo;
        mem_addr = '0;
        mem_wdata = '0;
        mem_mask = '0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        d = '0;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        // load miss right after reset
        a = make_addr(55'd1, 6'd5);
        access(a, 1'b0, d, 8'h00);
        check_flag(saw_read && !saw_write, "load miss did not refill through a bus read");
        compare_addr("bus_addr_o", rd_addr, a);

        // partial store and load back as hits
        d.word = 64'h1122_3344_5566_7788;
        access(a, 1'b1, d, 8'b0011_0100);
        check_flag(!saw_read && !saw_write, "store hit caused bus traffic");
        access(a, 1'b0, d, 8'h00);
        check_flag(!saw_read && !saw_write, "load hit caused bus traffic");
        check_flag(op_cycles == HIT_CYCLES, "hit done pulse came in the wrong cycle");

        // dirty line in way 0 evicted by the third tag of a set
        a = make_addr(55'd2, 6'd9);
        b = make_addr(55'd3, 6'd9);
        c = make_addr(55'd4, 6'd9);
        d.word = 64'hdead_beef_0bad_f00d;
        access(a, 1'b1, d, 8'hff);
        access(b, 1'b0, d, 8'h00);
        access(c, 1'b0, d, 8'h00);
        check_flag(saw_write && saw_read && !read_first,
                   "dirty victim was not written back before the refill");
        compare_addr("bus_addr_o", wb_addr, a);

        // A, B, A, C leaves A cached and B evicted
        a = make_addr(55'd5, 6'd12);
        b = make_addr(55'd6, 6'd12);
        c = make_addr(55'd7, 6'd12);
        access(a, 1'b0, d, 8'h00);
        access(b, 1'b0, d, 8'h00);
        access(a, 1'b0, d, 8'h00);
        access(c, 1'b0, d, 8'h00);
        access(a, 1'b0, d, 8'h00);
        check_flag(!saw_read, "recently used line was evicted");
        access(b, 1'b0, d, 8'h00);
        check_flag(saw_read, "least recently used line was still cached");

        // 16 tags over 4 sets
        for (int i = 0; i < NUM_OPS; i++) begin
            tag_bits = rand_bits(4);
            idx_bits = rand_bits(2);
            wr_bits = rand_bits(1);
            mask_bits = rand_bits(8);
            hi = rand_bits(32);
            lo = rand_bits(32);
            d.word = {hi, lo};
            a = make_addr({51'd16, tag_bits[3:0]}, {4'd8, idx_bits[1:0]});
            access(a, wr_bits[0], d, mask_bits[7:0]);
        end

        $display("errors: data %0d, address %0d, other %0d",
                 data_errors, addr_errors, other_errors);
        if (data_errors + addr_errors + other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb/dcache_tb_mem.sv */
// bus responder for the cache testbench, sparse backing memory with LFSR-chosen ok delays
module dcache_tb_mem (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::addr_t  bus_addr_i,
    input  dcache_pkg::data_u  bus_wdata_i,
    input  logic               bus_read_i,
    input  logic               bus_write_i,
    output dcache_pkg::data_u  bus_rdata_o,
    output logic               bus_ok_o
);
    timeunit 1ns;
    timeprecision 100ps;

    dcache_pkg::data_u mem [dcache_pkg::addr_t];
    logic [31:0]       lfsr = 32'h731a;
    int                wait_left;

    // words never written read back a pattern built from the whole address
    function automatic dcache_pkg::data_u fill_word(input dcache_pkg::addr_t a);
        dcache_pkg::data_u w;
        w.word = {a[31:0] ^ 32'h5a5a_c3c3, a[63:32] ^ a[31:0]};
        return w;
    endfunction

    // delay of 0 to 3 cycles, one LFSR step per bit
    function automatic int next_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return d;
    endfunction

    initial begin
        bus_ok_o = 1'b0;
        bus_rdata_o = '0;
        wait_left = -1;
        forever begin
            @(posedge clk);
            #1;
            if (bus_ok_o || !rst) begin
                bus_ok_o = 1'b0;
                wait_left = -1;
            end else if (bus_read_i || bus_write_i) begin
                if (wait_left < 0) begin
                    wait_left = next_delay();
                end
                if (wait_left == 0) begin
                    if (bus_write_i) begin
                        mem[bus_addr_i] = bus_wdata_i;
                    end else if (mem.exists(bus_addr_i)) begin
                        bus_rdata_o = mem[bus_addr_i];
                    end else begin
                        bus_rdata_o = fill_word(bus_addr_i);
                    end
                    bus_ok_o = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

endmodule

/* logic/dcache_top.sv */
// two-way write-back data cache top, connects core and bus ports to controller, ways, lookup and lru
module dcache_top (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::addr_t   mem_addr_i,
    input  dcache_pkg::data_u   mem_wdata_i,
    input  dcache_pkg::mask_t   mem_mask_i,
    input  logic                mem_read_i,
    input  logic                mem_write_i,
    output dcache_pkg::data_u   mem_rdata_o,
    output logic                mem_done_o,
    output dcache_pkg::addr_t   bus_addr_o,
    output dcache_pkg::data_u   bus_wdata_o,
    output logic                bus_read_o,
    output logic                bus_write_o,
    input  dcache_pkg::data_u   bus_rdata_i,
    input  logic                bus_ok_i
);

    logic               hit;
    logic               hit_way;
    dcache_pkg::data_u  hit_data;
    logic               victim_way;
    logic               victim_dirty;
    dcache_pkg::addr_t  victim_addr;
    dcache_pkg::data_u  victim_data;
    logic               lru_victim;
    logic               touch;
    logic               touch_way;

    dcache_way_if way0_if ();
    dcache_way_if way1_if ();

    dcache_ctrl dcache_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .mem_addr_i     (mem_addr_i),
        .mem_wdata_i    (mem_wdata_i),
        .mem_mask_i     (mem_mask_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .mem_rdata_o    (mem_rdata_o),
        .mem_done_o     (mem_done_o),
        .bus_addr_o     (bus_addr_o),
        .bus_wdata_o    (bus_wdata_o),
        .bus_read_o     (bus_read_o),
        .bus_write_o    (bus_write_o),
        .bus_rdata_i    (bus_rdata_i),
        .bus_ok_i       (bus_ok_i),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .hit_data_i     (hit_data),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_addr_i  (victim_addr),
        .victim_data_i  (victim_data),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .way0           (way0_if),
        .way1           (way1_if)
    );

    dcache_way way0 (
        .clk  (clk),
        .rst  (rst),
        .port (way0_if)
    );

    dcache_way way1 (
        .clk  (clk),
        .rst  (rst),
        .port (way1_if)
    );

    dcache_lookup dcache_lookup_i (
        .mem_addr_i     (mem_addr_i),
        .lru_victim_i   (lru_victim),
        .way0           (way0_if),
        .way1           (way1_if),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .hit_data_o     (hit_data),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr),
        .victim_data_o  (victim_data)
    );

    dcache_lru dcache_lru_i (
        .clk         (clk),
        .rst         (rst),
        .index_i     (mem_addr_i[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W]),
        .touch_i     (touch),
        .touch_way_i (touch_way),
        .victim_o    (lru_victim)
    );

endmodule

/* logic/dcache_ctrl.sv */
// cache controller FSM, sequences lookup, hit, dirty writeback and refill for one request
module dcache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::addr_t   mem_addr_i,
    input  dcache_pkg::data_u   mem_wdata_i,
    input  dcache_pkg::mask_t   mem_mask_i,
    input  logic                mem_read_i,
    input  logic                mem_write_i,
    output dcache_pkg::data_u   mem_rdata_o,
    output logic                mem_done_o,
    output dcache_pkg::addr_t   bus_addr_o,
    output dcache_pkg::data_u   bus_wdata_o,
    output logic                bus_read_o,
    output logic                bus_write_o,
    input  dcache_pkg::data_u   bus_rdata_i,
    input  logic                bus_ok_i,
    input  logic                hit_i,
    input  logic                hit_way_i,
    input  dcache_pkg::data_u   hit_data_i,
    input  logic                victim_way_i,
    input  logic                victim_dirty_i,
    input  dcache_pkg::addr_t   victim_addr_i,
    input  dcache_pkg::data_u   victim_data_i,
    output logic                touch_o,
    output logic                touch_way_o,
    dcache_way_if.ctrl          way0,
    dcache_way_if.ctrl          way1
);

    dcache_pkg::state_e state;
    dcache_pkg::state_e state_nxt;
    logic               store_hit;
    logic               fill;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (mem_read_i || mem_write_i) begin
                    state_nxt = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit_i) begin
                    state_nxt = dcache_pkg::HIT;
                end else if (victim_dirty_i) begin
                    state_nxt = dcache_pkg::WBACK;
                end else begin
                    state_nxt = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::HIT:    state_nxt = dcache_pkg::IDLE;
            dcache_pkg::WBACK: begin
                if (bus_ok_i) begin
                    state_nxt = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (bus_ok_i) begin
                    state_nxt = dcache_pkg::RETRY;
                end
            end
            // one cycle for the filled way to show up on the read ports
            dcache_pkg::RETRY:  state_nxt = dcache_pkg::LOOKUP;
            default:            state_nxt = dcache_pkg::IDLE;
        endcase
    end

    assign store_hit = (state == dcache_pkg::HIT) && mem_write_i;
    assign fill      = (state == dcache_pkg::REFILL) && bus_ok_i;

    // core side
    assign mem_done_o  = (state == dcache_pkg::HIT);
    assign mem_rdata_o = mem_done_o ? hit_data_i : '0;
    assign touch_o     = (state == dcache_pkg::HIT);
    assign touch_way_o = hit_way_i;

    // bus side, victim line on writeback, aligned request line on refill
    assign bus_write_o = (state == dcache_pkg::WBACK);
    assign bus_read_o  = (state == dcache_pkg::REFILL);
    assign bus_addr_o  = bus_write_o ? victim_addr_i
                       : {mem_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                          {dcache_pkg::OFFSET_W{1'b0}}};
    assign bus_wdata_o = victim_data_i;

    // way 0 controls
    assign way0.index     = mem_addr_i[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign way0.wr_tag    = mem_addr_i[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign way0.wr_mask   = mem_mask_i;
    assign way0.wr_data   = fill ? bus_rdata_i : mem_wdata_i;
    assign way0.wr_en     = store_hit && !hit_way_i;
    assign way0.dirty_set = store_hit && !hit_way_i;
    assign way0.fill_en   = fill && !victim_way_i;

    // way 1 controls
    assign way1.index     = mem_addr_i[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign way1.wr_tag    = mem_addr_i[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign way1.wr_mask   = mem_mask_i;
    assign way1.wr_data   = fill ? bus_rdata_i : mem_wdata_i;
    assign way1.wr_en     = store_hit && hit_way_i;
    assign way1.dirty_set = store_hit && hit_way_i;
    assign way1.fill_en   = fill && victim_way_i;

endmodule

/* logic/dcache_lru.sv */
// one lru bit per set naming the way to replace next
module dcache_lru (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::index_t  index_i,
    input  logic                touch_i,
    input  logic                touch_way_i,
    output logic                victim_o
);

    logic [dcache_pkg::NUM_SETS-1:0] lru;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lru <= '0;
        end else if (touch_i) begin
            // the way not just used becomes least recent
            lru[index_i] <= !touch_way_i;
        end
    end

    assign victim_o = lru[index_i];

endmodule

/* logic/dcache_lookup.sv */
// tag compare over both ways, read data mux and victim selection for the current request
module dcache_lookup (
    input  dcache_pkg::addr_t   mem_addr_i,
    input  logic                lru_victim_i,
    dcache_way_if.peek          way0,
    dcache_way_if.peek          way1,
    output logic                hit_o,
    output logic                hit_way_o,
    output dcache_pkg::data_u   hit_data_o,
    output logic                victim_way_o,
    output logic                victim_dirty_o,
    output dcache_pkg::addr_t   victim_addr_o,
    output dcache_pkg::data_u   victim_data_o
);

    dcache_pkg::tag_t   req_tag;
    dcache_pkg::index_t req_index;
    dcache_pkg::tag_t   victim_tag;
    logic               hit0;
    logic               hit1;

    assign req_tag   = mem_addr_i[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_index = mem_addr_i[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];

    assign hit0 = way0.rd_valid && (way0.rd_tag == req_tag);
    assign hit1 = way1.rd_valid && (way1.rd_tag == req_tag);

    assign hit_o      = hit0 || hit1;
    assign hit_way_o  = !hit0 && hit1;
    assign hit_data_o = hit_way_o ? way1.rd_data : way0.rd_data;

    // empty way first, way 0 preferred, then the lru pick
    always_comb begin
        if (!way0.rd_valid) begin
            victim_way_o = 1'b0;
        end else if (!way1.rd_valid) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_victim_i;
        end
    end

    assign victim_dirty_o = victim_way_o ? (way1.rd_valid && way1.rd_dirty)
                                         : (way0.rd_valid && way0.rd_dirty);
    assign victim_data_o  = victim_way_o ? way1.rd_data : way0.rd_data;
    assign victim_tag     = victim_way_o ? way1.rd_tag  : way0.rd_tag;

    // writeback address of the line being evicted
    assign victim_addr_o = {victim_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};

endmodule

/* logic/dcache_way.sv */
// one cache way, tag/valid/dirty/data arrays with combinational read and masked byte write
module dcache_way (
    input  logic        clk,
    input  logic        rst,
    dcache_way_if.store port
);

    dcache_pkg::tag_t                 tag_mem  [dcache_pkg::NUM_SETS];
    dcache_pkg::data_u                data_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0]  valid;
    logic [dcache_pkg::NUM_SETS-1:0]  dirty;

    // status bits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (port.fill_en) begin
            valid[port.index] <= 1'b1;
            dirty[port.index] <= 1'b0;
        end else if (port.dirty_set) begin
            dirty[port.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.fill_en) begin
            tag_mem[port.index] <= port.wr_tag;
        end
    end

    // full word on fill, enabled byte lanes on store
    always_ff @(posedge clk) begin
        if (port.fill_en) begin
            data_mem[port.index].word <= port.wr_data.word;
        end else if (port.wr_en) begin
            for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
                if (port.wr_mask[b]) begin
                    data_mem[port.index].bytes[b] <= port.wr_data.bytes[b];
                end
            end
        end
    end

    assign port.rd_tag   = tag_mem[port.index];
    assign port.rd_valid = valid[port.index];
    assign port.rd_dirty = dirty[port.index];
    assign port.rd_data  = data_mem[port.index];

endmodule

/* logic/dcache_way_if.sv */
// per-way bundle between the controller, the way storage and the lookup logic
interface dcache_way_if;

    // controller to way
    dcache_pkg::index_t index;
    logic               wr_en;
    dcache_pkg::mask_t  wr_mask;
    dcache_pkg::data_u  wr_data;
    dcache_pkg::tag_t   wr_tag;
    logic               fill_en;
    logic               dirty_set;

    // way to controller and lookup
    dcache_pkg::tag_t   rd_tag;
    logic               rd_valid;
    logic               rd_dirty;
    dcache_pkg::data_u  rd_data;

    modport ctrl (
        output index, wr_en, wr_mask, wr_data, wr_tag, fill_en, dirty_set,
        input  rd_tag, rd_valid, rd_dirty, rd_data
    );

    modport store (
        input  index, wr_en, wr_mask, wr_data, wr_tag, fill_en, dirty_set,
        output rd_tag, rd_valid, rd_dirty, rd_data
    );

    modport peek (
        input  rd_tag, rd_valid, rd_dirty, rd_data
    );

endinterface

/* logic/dcache_pkg.sv */
// shared cache geometry, controller states and data word type, referenced by scoped names
package dcache_pkg;

    // address split: tag 63:9, index 8:3, offset 2:0
    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int MASK_W   = 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [MASK_W-1:0]  mask_t;

    // whole word for fills and bus traffic, byte lanes for masked stores
    typedef union packed {
        logic [DATA_W-1:0]               word;
        logic [MASK_W-1:0][7:0]          bytes;
    } data_u;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        HIT    = 3'd2,
        WBACK  = 3'd3,
        REFILL = 3'd4,
        RETRY  = 3'd5
    } state_e;

endpackage
